// ==== filelist.f ====
rtl/exe_pkg.sv
rtl/exe_operand_decode.sv
rtl/exe_alu.sv
rtl/exe_mem_result.sv
rtl/exe_pipe_reg.sv
rtl/execute_stage.sv
dv/execute_stage_checker.sv
dv/execute_stage_tb.sv

// ==== dv/execute_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage_tb;

  localparam int CYCLES_PER_ITEM = 20;

  logic              clk;
  logic              rst;
  logic              id_valid;
  exe_pkg::id_exe_t  id_data;
  logic              exe_allowin;
  logic              exe_valid;
  exe_pkg::exe_mem_t exe_data;
  logic              mem_allowin;

  exe_pkg::id_exe_t  stim[$];
  exe_pkg::exe_mem_t expect_tab[$];
  exe_pkg::exe_mem_t exp_q[$];
  longint            acc_q[$];
  longint            cycle = 0;
  int                accepted = 0;
  int                seen = 0;
  bit                hold_phase = 1'b0;
  bit                table_ready = 1'b0;

  execute_stage dut0 (
    .clk         (clk),
    .rst         (rst),
    .id_valid    (id_valid),
    .id_data     (id_data),
    .exe_allowin (exe_allowin),
    .exe_valid   (exe_valid),
    .exe_data    (exe_data),
    .mem_allowin (mem_allowin)
  );

  always #50 clk = ~clk;

  //////////////////////////////
  // Compare tasks
  //////////////////////////////
  task automatic stop_run();
    $display("Result: FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(input string name, input exe_pkg::word_t exp,
                            input exe_pkg::word_t act);
    if (act !== exp) begin
      $display("error: %0t %s expected %h actual %h", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_byte_en(input string name, input exe_pkg::byte_en_t exp,
                               input exe_pkg::byte_en_t act);
    if (act !== exp) begin
      $display("error: %0t %s expected %b actual %b", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_exc(input string name, input exe_pkg::exc_t exp, input exe_pkg::exc_t act);
    if (act !== exp) begin
      $display("error: %0t %s expected %b actual %b", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_access(input string name, input exe_pkg::mem_access_e exp,
                              input exe_pkg::mem_access_e act);
    if (act !== exp) begin
      $display("error: %0t %s expected %s actual %s", $time, name, exp.name(), act.name());
      stop_run();
    end
  endtask

  task automatic check_reg_addr(input string name, input exe_pkg::reg_addr_t exp,
                                input exe_pkg::reg_addr_t act);
    if (act !== exp) begin
      $display("error: %0t %s expected %0d actual %0d", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error: %0t %s expected %b actual %b", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic compare_item(input exe_pkg::exe_mem_t exp, input exe_pkg::exe_mem_t act);
    check_word("pc", exp.pc, act.pc);
    check_word("alu_result", exp.alu_result, act.alu_result);
    check_word("mem_wdata", exp.mem_wdata, act.mem_wdata);
    check_byte_en("byte_en", exp.byte_en, act.byte_en);
    check_access("mem_access", exp.mem_access, act.mem_access);
    check_reg_addr("reg_waddr", exp.reg_waddr, act.reg_waddr);
    check_bit("reg_write", exp.reg_write, act.reg_write);
    check_exc("exc", exp.exc, act.exc);
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////
  function automatic exe_pkg::exe_mem_t model(input exe_pkg::id_exe_t d);
    exe_pkg::exe_mem_t m;
    exe_pkg::word_t    a;
    exe_pkg::word_t    b;
    longint            wide;
    logic [1:0]        off;
    m = '0;
    wide = 0;
    case (d.src_a)
      exe_pkg::SRC_A_PC_PLUS4: a = d.pc + 32'd4;
      exe_pkg::SRC_A_SA:       a = {27'd0, d.sa};
      default:                 a = d.rs_data;
    endcase
    case (d.src_b)
      exe_pkg::SRC_B_SIMM:   b = {{16{d.imm16[15]}}, d.imm16};
      exe_pkg::SRC_B_ZIMM:   b = {16'd0, d.imm16};
      exe_pkg::SRC_B_CONST4: b = 32'd4;
      default:               b = d.rt_data;
    endcase
    // 64-bit signed sum tells overflow directly
    case (d.alu_op)
      exe_pkg::ALU_ADD, exe_pkg::ALU_ADDU: begin
        wide = longint'($signed(a)) + longint'($signed(b));
        m.alu_result = a + b;
      end
      exe_pkg::ALU_SUB, exe_pkg::ALU_SUBU: begin
        wide = longint'($signed(a)) - longint'($signed(b));
        m.alu_result = a - b;
      end
      exe_pkg::ALU_AND:  m.alu_result = a & b;
      exe_pkg::ALU_OR:   m.alu_result = a | b;
      exe_pkg::ALU_XOR:  m.alu_result = a ^ b;
      exe_pkg::ALU_NOR:  m.alu_result = ~(a | b);
      exe_pkg::ALU_SLT:  m.alu_result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      exe_pkg::ALU_SLTU: m.alu_result = (a < b) ? 32'd1 : 32'd0;
      exe_pkg::ALU_SLL:  m.alu_result = b << a[4:0];
      exe_pkg::ALU_SRL:  m.alu_result = b >> a[4:0];
      exe_pkg::ALU_SRA:  m.alu_result = $unsigned($signed(b) >>> a[4:0]);
      default:           m.alu_result = {b[15:0], 16'd0};
    endcase
    m.exc.overflow = (d.alu_op == exe_pkg::ALU_ADD || d.alu_op == exe_pkg::ALU_SUB) &&
                     (wide > 64'sh7fff_ffff || wide < -64'sh8000_0000);
    off = m.alu_result[1:0];
    m.mem_wdata = d.rt_data;
    case (d.mem_access)
      exe_pkg::MEM_SB: begin
        m.mem_wdata = '0;
        m.mem_wdata[8*off +: 8] = d.rt_data[7:0];
        m.byte_en[off] = 1'b1;
      end
      exe_pkg::MEM_SH: begin
        m.mem_wdata = off[1] ? {d.rt_data[15:0], 16'd0} : {16'd0, d.rt_data[15:0]};
        m.byte_en   = off[1] ? 4'b1100 : 4'b0011;
        m.exc.ades  = off[0];
      end
      exe_pkg::MEM_SW: begin
        m.byte_en  = 4'b1111;
        m.exc.ades = (off != 2'b00);
      end
      exe_pkg::MEM_LH, exe_pkg::MEM_LHU: m.exc.adel = off[0];
      exe_pkg::MEM_LW:                   m.exc.adel = (off != 2'b00);
      default: ;
    endcase
    m.pc         = d.pc;
    m.mem_access = d.mem_access;
    m.reg_waddr  = d.reg_waddr;
    m.reg_write  = d.reg_write;
    if (m.exc.overflow || m.exc.adel || m.exc.ades) begin
      m.byte_en   = '0;
      m.reg_write = 1'b0;
    end
    return m;
  endfunction

  //////////////////////////////
  // Table and driver
  //////////////////////////////
  function automatic exe_pkg::id_exe_t alu_item(input exe_pkg::alu_op_e op,
      input exe_pkg::src_a_e a_sel, input exe_pkg::src_b_e b_sel,
      input exe_pkg::word_t rs, input exe_pkg::word_t rt, input exe_pkg::word_t imm);
    exe_pkg::id_exe_t d;
    exe_pkg::word_t   r;
    r = $urandom;
    d = '0;
    d.pc         = {r[31:2], 2'b00};
    d.rs_data    = rs;
    d.rt_data    = rt;
    // Upper bits of imm feed the unused fields
    d.sa         = imm[20:16];
    d.imm16      = imm[15:0];
    d.src_a      = a_sel;
    d.src_b      = b_sel;
    d.alu_op     = op;
    d.mem_access = exe_pkg::MEM_NONE;
    d.reg_waddr  = imm[25:21];
    d.reg_write  = 1'b1;
    return d;
  endfunction

  task automatic add_entry(input exe_pkg::id_exe_t d);
    stim.push_back(d);
    expect_tab.push_back(model(d));
  endtask

  task automatic apply_table(input bit hold_high);
    int i;
    bit taken;
    i = 0;
    while (i < stim.size()) begin
      @(posedge clk);
      taken = id_valid && exe_allowin;
      if (taken) i++;
      mem_allowin <= hold_high ? 1'b1 : ($urandom_range(3) != 0);
      if (i >= stim.size()) begin
        id_valid <= 1'b0;
      end else if (taken || !id_valid) begin
        // Offered items stay until taken
        id_valid <= ($urandom_range(3) != 0);
        id_data  <= stim[i];
      end
    end
  endtask

  task automatic drain();
    mem_allowin <= 1'b1;
    do begin
      @(posedge clk);
    end while (exp_q.size() != 0 || exe_valid);
  endtask

  initial begin
    int o;
    int a;
    int b;
    int acc;
    exe_pkg::id_exe_t d;
    void'($urandom(98));
    clk         = 1'b0;
    rst         = 1'b1;
    id_valid    = 1'b0;
    id_data     = '0;
    mem_allowin = 1'b0;
    // Every op under every operand source
    for (o = 0; o < 14; o++) begin
      for (a = 0; a < 3; a++) begin
        for (b = 0; b < 4; b++) begin
          add_entry(alu_item(exe_pkg::alu_op_e'(o), exe_pkg::src_a_e'(a),
                             exe_pkg::src_b_e'(b), $urandom, $urandom, $urandom));
        end
      end
    end
    add_entry(alu_item(exe_pkg::ALU_ADD, exe_pkg::SRC_A_RS, exe_pkg::SRC_B_RT,
                       32'h7fff_ffff, 32'h1, 32'h0));
    add_entry(alu_item(exe_pkg::ALU_ADDU, exe_pkg::SRC_A_RS, exe_pkg::SRC_B_RT,
                       32'h7fff_ffff, 32'h1, 32'h0));
    add_entry(alu_item(exe_pkg::ALU_SUB, exe_pkg::SRC_A_RS, exe_pkg::SRC_B_RT,
                       32'h8000_0000, 32'h1, 32'h0));
    add_entry(alu_item(exe_pkg::ALU_SUBU, exe_pkg::SRC_A_RS, exe_pkg::SRC_B_RT,
                       32'h8000_0000, 32'h1, 32'h0));
    add_entry(alu_item(exe_pkg::ALU_ADD, exe_pkg::SRC_A_RS, exe_pkg::SRC_B_SIMM,
                       32'h8000_0000, 32'h0, 32'hffff));
    add_entry(alu_item(exe_pkg::ALU_ADDU, exe_pkg::SRC_A_RS, exe_pkg::SRC_B_SIMM,
                       32'h0, 32'h0, 32'h8000));
    add_entry(alu_item(exe_pkg::ALU_ADDU, exe_pkg::SRC_A_RS, exe_pkg::SRC_B_ZIMM,
                       32'h0, 32'h0, 32'h8000));
    // Each access type at each byte offset
    for (acc = 0; acc < 9; acc++) begin
      for (o = 0; o < 4; o++) begin
        d = alu_item(exe_pkg::ALU_ADDU, exe_pkg::SRC_A_RS, exe_pkg::SRC_B_SIMM,
                     $urandom & 32'hffff_fffc, $urandom, o);
        d.mem_access = exe_pkg::mem_access_e'(acc);
        d.reg_write  = (acc < 6);
        add_entry(d);
      end
    end
    table_ready = 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_bit("exe_valid", 1'b0, exe_valid);
    check_bit("exe_allowin", 1'b1, exe_allowin);
    apply_table(1'b0);
    drain();
    hold_phase = 1'b1;
    apply_table(1'b1);
    drain();
    // Assertions of the last rising edge settle before this
    @(negedge clk);
    if (dut0.u_checker.fail_count != 0) begin
      $display("an assertion in the handshake checker failed");
      stop_run();
    end else if (seen == 2 * stim.size() && accepted == seen) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("error: only %0d of %0d items reached the output", seen, 2 * stim.size());
      stop_run();
    end
  end

  //////////////////////////////
  // Scoreboard and watchdog
  //////////////////////////////
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (dut0.u_checker.fail_count != 0) begin
      $display("an assertion in the handshake checker failed");
      stop_run();
    end
    if (!rst && exe_valid && mem_allowin) begin
      if (exp_q.size() == 0) begin
        $display("exe_valid was high with no item expected at %0t", $time);
        stop_run();
      end else begin
        if (hold_phase && acc_q[0] != cycle - 1) begin
          $display("item accepted at cycle %0d left at cycle %0d, not one cycle later",
                   acc_q[0], cycle);
          stop_run();
        end
        compare_item(exp_q.pop_front(), exe_data);
        void'(acc_q.pop_front());
        seen++;
      end
    end
    // Item leaving this edge was accepted earlier, so pop before push
    if (!rst && id_valid && exe_allowin) begin
      exp_q.push_back(expect_tab[accepted % expect_tab.size()]);
      acc_q.push_back(cycle);
      accepted++;
    end
  end

  initial begin
    wait (table_ready);
    repeat (2 * stim.size() * CYCLES_PER_ITEM + 20) #100;
    $display("timeout: the table did not get through the stage in time");
    stop_run();
  end

endmodule

`default_nettype wire

// ==== dv/execute_stage_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage_checker (
  input logic              clk,
  input logic              rst,
  input logic              exe_valid,
  input logic              exe_allowin,
  input logic              mem_allowin,
  input exe_pkg::exe_mem_t exe_data
);

  int unsigned fail_count = 0;

  //////////////////////////////
  // Handshake
  //////////////////////////////
  allowin_when_empty: assert property (
    @(posedge clk) disable iff (rst) !exe_valid |-> exe_allowin)
    else begin
      $error("exe_allowin low while the register is empty");
      fail_count++;
    end

  // Held item must not move under back-pressure
  hold_under_stall: assert property (
    @(posedge clk) disable iff (rst)
    exe_valid && !mem_allowin |=> exe_valid && $stable(exe_data))
    else begin
      $error("exe_data or exe_valid changed while stalled");
      fail_count++;
    end

  squash_on_exc: assert property (
    @(posedge clk) disable iff (rst)
    (exe_data.exc.overflow || exe_data.exc.adel || exe_data.exc.ades) |->
      (exe_data.byte_en == '0) && !exe_data.reg_write)
    else begin
      $error("writes not squashed on exception");
      fail_count++;
    end

  empty_after_reset: assert property (@(posedge clk) rst |=> !exe_valid)
    else begin
      $error("exe_valid high after reset");
      fail_count++;
    end

endmodule

bind execute_stage execute_stage_checker u_checker (.*);

`default_nettype wire

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  logic              clk,
  input  logic              rst,
  input  logic              id_valid,
  input  exe_pkg::id_exe_t  id_data,
  output logic              exe_allowin,
  output logic              exe_valid,
  output exe_pkg::exe_mem_t exe_data,
  input  logic              mem_allowin
);

  exe_pkg::word_t    operand_a;
  exe_pkg::word_t    operand_b;
  logic              is_signed_op;
  logic              is_store;
  logic              is_load;
  exe_pkg::word_t    alu_result;
  logic              overflow;
  exe_pkg::exe_mem_t result_data;

  //////////////////////////////
  // Combinational datapath
  //////////////////////////////
  exe_operand_decode u_decode (
    .id_data      (id_data),
    .operand_a    (operand_a),
    .operand_b    (operand_b),
    .is_signed_op (is_signed_op),
    .is_store     (is_store),
    .is_load      (is_load)
  );

  exe_alu u_alu (
    .operand_a    (operand_a),
    .operand_b    (operand_b),
    .alu_op       (id_data.alu_op),
    .is_signed_op (is_signed_op),
    .alu_result   (alu_result),
    .overflow     (overflow)
  );

  exe_mem_result u_result (
    .id_data    (id_data),
    .alu_result (alu_result),
    .overflow   (overflow),
    .is_load    (is_load),
    .is_store   (is_store),
    .mem_data   (result_data)
  );

  //////////////////////////////
  // Register toward memory stage
  //////////////////////////////
  exe_pipe_reg u_pipe_reg (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (id_valid),
    .in_data     (result_data),
    .allowin     (exe_allowin),
    .out_valid   (exe_valid),
    .out_data    (exe_data),
    .out_allowin (mem_allowin)
  );

endmodule

`default_nettype wire

// ==== rtl/exe_pipe_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_pipe_reg (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,
  input  exe_pkg::exe_mem_t in_data,
  output logic              allowin,
  output logic              out_valid,
  output exe_pkg::exe_mem_t out_data,
  input  logic              out_allowin
);

  logic              valid_q;
  exe_pkg::exe_mem_t data_q;

  // Free slot, or the held item leaves this cycle
  assign allowin = !valid_q || out_allowin;

  //////////////////////////////
  // Valid bit
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (allowin) begin
      // Drops to zero when the item leaves with nothing behind it
      valid_q <= in_valid;
    end
  end

  //////////////////////////////
  // Payload
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      data_q <= '0;
    end else if (in_valid && allowin) begin
      data_q <= in_data;
    end
  end

  assign out_valid = valid_q;
  assign out_data  = data_q;

endmodule

`default_nettype wire

// ==== rtl/exe_mem_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_mem_result (
  input  exe_pkg::id_exe_t  id_data,
  input  exe_pkg::word_t    alu_result,
  input  logic              overflow,
  input  logic              is_load,
  input  logic              is_store,
  output exe_pkg::exe_mem_t mem_data
);

  logic [1:0]         lane;
  logic               half_access;
  logic               word_access;
  logic               misaligned;
  exe_pkg::exc_t      exc;
  logic               any_exc;
  exe_pkg::byte_en_t  byte_en;
  exe_pkg::word_t     wdata;

  assign lane = alu_result[1:0];

  //////////////////////////////
  // Address errors
  //////////////////////////////
  assign half_access = (id_data.mem_access == exe_pkg::MEM_LH)  ||
                       (id_data.mem_access == exe_pkg::MEM_LHU) ||
                       (id_data.mem_access == exe_pkg::MEM_SH);
  assign word_access = (id_data.mem_access == exe_pkg::MEM_LW) ||
                       (id_data.mem_access == exe_pkg::MEM_SW);

  // Byte accesses never fault
  assign misaligned = (half_access && lane[0]) || (word_access && (lane != 2'b00));

  assign exc.overflow = overflow;
  assign exc.adel     = is_load && misaligned;
  assign exc.ades     = is_store && misaligned;
  assign any_exc      = exc.overflow || exc.adel || exc.ades;

  //////////////////////////////
  // Store lanes
  //////////////////////////////
  always_comb begin
    byte_en = '0;
    wdata   = id_data.rt_data;
    case (id_data.mem_access)
      exe_pkg::MEM_SB: begin
        byte_en = exe_pkg::byte_en_t'(1) << lane;
        wdata   = exe_pkg::word_t'(id_data.rt_data[7:0]) << {lane, 3'b000};
      end
      exe_pkg::MEM_SH: begin
        // Upper or lower half by address bit 1
        if (lane[1]) begin
          byte_en = 4'b1100;
          wdata   = {id_data.rt_data[15:0], 16'h0000};
        end else begin
          byte_en = 4'b0011;
          wdata   = {16'h0000, id_data.rt_data[15:0]};
        end
      end
      exe_pkg::MEM_SW: begin
        byte_en = 4'b1111;
      end
      default: begin
        byte_en = '0;
      end
    endcase
  end

  //////////////////////////////
  // Output payload
  //////////////////////////////
  always_comb begin
    mem_data.pc         = id_data.pc;
    mem_data.alu_result = alu_result;
    mem_data.mem_wdata  = wdata;
    mem_data.mem_access = id_data.mem_access;
    mem_data.reg_waddr  = id_data.reg_waddr;
    mem_data.exc        = exc;
    // A faulting instruction must not touch memory or the register file
    mem_data.byte_en    = any_exc ? '0 : byte_en;
    mem_data.reg_write  = id_data.reg_write && !any_exc;
  end

endmodule

`default_nettype wire

// ==== rtl/exe_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_alu (
  input  exe_pkg::word_t   operand_a,
  input  exe_pkg::word_t   operand_b,
  input  exe_pkg::alu_op_e alu_op,
  input  logic             is_signed_op,
  output exe_pkg::word_t   alu_result,
  output logic             overflow
);

  logic                        is_sub;
  exe_pkg::word_t              b_eff;
  exe_pkg::word_t              sum;
  logic                        add_ovf;
  logic                        slt_bit;
  logic                        sltu_bit;
  logic [exe_pkg::SHAMT_W-1:0] shamt;

  //////////////////////////////
  // Shared adder
  //////////////////////////////
  assign is_sub = (alu_op == exe_pkg::ALU_SUB) || (alu_op == exe_pkg::ALU_SUBU);

  // Subtract as a + ~b + 1
  assign b_eff = is_sub ? ~operand_b : operand_b;
  assign sum   = operand_a + b_eff + exe_pkg::word_t'(is_sub);

  // Same input signs, different result sign
  assign add_ovf = (operand_a[exe_pkg::DATA_W-1] == b_eff[exe_pkg::DATA_W-1]) &&
                   (sum[exe_pkg::DATA_W-1] != operand_a[exe_pkg::DATA_W-1]);

  assign overflow = add_ovf && is_signed_op;

  assign slt_bit  = $signed(operand_a) < $signed(operand_b);
  assign sltu_bit = operand_a < operand_b;

  // Shift amount comes from the low bits of A
  assign shamt = operand_a[exe_pkg::SHAMT_W-1:0];

  //////////////////////////////
  // Result select
  //////////////////////////////
  always_comb begin
    case (alu_op)
      exe_pkg::ALU_ADD,
      exe_pkg::ALU_ADDU,
      exe_pkg::ALU_SUB,
      exe_pkg::ALU_SUBU: alu_result = sum;
      exe_pkg::ALU_AND:  alu_result = operand_a & operand_b;
      exe_pkg::ALU_OR:   alu_result = operand_a | operand_b;
      exe_pkg::ALU_XOR:  alu_result = operand_a ^ operand_b;
      exe_pkg::ALU_NOR:  alu_result = ~(operand_a | operand_b);
      exe_pkg::ALU_SLT:  alu_result = exe_pkg::word_t'(slt_bit);
      exe_pkg::ALU_SLTU: alu_result = exe_pkg::word_t'(sltu_bit);
      exe_pkg::ALU_SLL:  alu_result = operand_b << shamt;
      exe_pkg::ALU_SRL:  alu_result = operand_b >> shamt;
      exe_pkg::ALU_SRA:  alu_result = exe_pkg::word_t'($signed(operand_b) >>> shamt);
      exe_pkg::ALU_LUI: begin
        alu_result = {operand_b[exe_pkg::IMM_W-1:0],
                      {(exe_pkg::DATA_W - exe_pkg::IMM_W){1'b0}}};
      end
      default:           alu_result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/exe_operand_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_operand_decode (
  input  exe_pkg::id_exe_t id_data,
  output exe_pkg::word_t   operand_a,
  output exe_pkg::word_t   operand_b,
  output logic             is_signed_op,
  output logic             is_store,
  output logic             is_load
);

  exe_pkg::word_t simm;
  exe_pkg::word_t zimm;
  exe_pkg::word_t pc_plus4;
  exe_pkg::word_t shamt;

  //////////////////////////////
  // Extended fields
  //////////////////////////////
  assign simm = {{(exe_pkg::DATA_W - exe_pkg::IMM_W){id_data.imm16[exe_pkg::IMM_W-1]}},
                 id_data.imm16};
  assign zimm = {{(exe_pkg::DATA_W - exe_pkg::IMM_W){1'b0}}, id_data.imm16};

  // Link address for jal and friends
  assign pc_plus4 = id_data.pc + exe_pkg::word_t'(4);
  assign shamt    = {{(exe_pkg::DATA_W - exe_pkg::SHAMT_W){1'b0}}, id_data.sa};

  //////////////////////////////
  // Operand muxes
  //////////////////////////////
  always_comb begin
    case (id_data.src_a)
      exe_pkg::SRC_A_RS:       operand_a = id_data.rs_data;
      exe_pkg::SRC_A_PC_PLUS4: operand_a = pc_plus4;
      exe_pkg::SRC_A_SA:       operand_a = shamt;
      default:                 operand_a = '0;
    endcase
  end

  always_comb begin
    case (id_data.src_b)
      exe_pkg::SRC_B_RT:     operand_b = id_data.rt_data;
      exe_pkg::SRC_B_SIMM:   operand_b = simm;
      exe_pkg::SRC_B_ZIMM:   operand_b = zimm;
      exe_pkg::SRC_B_CONST4: operand_b = exe_pkg::word_t'(4);
      default:               operand_b = id_data.rt_data;
    endcase
  end

  // Only add and sub trap on overflow
  assign is_signed_op = (id_data.alu_op == exe_pkg::ALU_ADD) ||
                        (id_data.alu_op == exe_pkg::ALU_SUB);

  assign is_load  = (id_data.mem_access == exe_pkg::MEM_LB)  ||
                    (id_data.mem_access == exe_pkg::MEM_LBU) ||
                    (id_data.mem_access == exe_pkg::MEM_LH)  ||
                    (id_data.mem_access == exe_pkg::MEM_LHU) ||
                    (id_data.mem_access == exe_pkg::MEM_LW);
  assign is_store = (id_data.mem_access == exe_pkg::MEM_SB) ||
                    (id_data.mem_access == exe_pkg::MEM_SH) ||
                    (id_data.mem_access == exe_pkg::MEM_SW);

endmodule

`default_nettype wire

// ==== rtl/exe_pkg.sv ====
`default_nettype none

package exe_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////
  localparam int DATA_W     = 32;
  localparam int REG_ADDR_W = 5;
  localparam int IMM_W      = 16;
  localparam int SHAMT_W    = 5;
  localparam int BYTE_EN_W  = DATA_W / 8;

  typedef logic [DATA_W-1:0]     word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [BYTE_EN_W-1:0]  byte_en_t;

  //////////////////////////////
  // Operation and source codes
  //////////////////////////////
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_ADDU,
    ALU_SUB,
    ALU_SUBU,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_LUI
  } alu_op_e;

  // Operand A comes from rs, the link address or the shift field
  typedef enum logic [1:0] {
    SRC_A_RS,
    SRC_A_PC_PLUS4,
    SRC_A_SA
  } src_a_e;

  typedef enum logic [1:0] {
    SRC_B_RT,
    SRC_B_SIMM,
    SRC_B_ZIMM,
    SRC_B_CONST4
  } src_b_e;

  typedef enum logic [3:0] {
    MEM_NONE,
    MEM_LB,
    MEM_LBU,
    MEM_LH,
    MEM_LHU,
    MEM_LW,
    MEM_SB,
    MEM_SH,
    MEM_SW
  } mem_access_e;

  //////////////////////////////
  // Stage payloads
  //////////////////////////////
  typedef struct packed {
    logic overflow;
    logic adel;
    logic ades;
  } exc_t;

  // Decoded instruction handed over by the decode stage
  typedef struct packed {
    word_t                pc;
    word_t                rs_data;
    word_t                rt_data;
    logic [SHAMT_W-1:0]   sa;
    logic [IMM_W-1:0]     imm16;
    src_a_e               src_a;
    src_b_e               src_b;
    alu_op_e              alu_op;
    mem_access_e          mem_access;
    reg_addr_t            reg_waddr;
    logic                 reg_write;
  } id_exe_t;

  // Result handed to the memory stage
  typedef struct packed {
    word_t       pc;
    word_t       alu_result;
    word_t       mem_wdata;
    byte_en_t    byte_en;
    mem_access_e mem_access;
    reg_addr_t   reg_waddr;
    logic        reg_write;
    exc_t        exc;
  } exe_mem_t;

endpackage

`default_nettype wire
